/* ghrd_io_top.f */
src/ghrd_io_pkg.sv
src/apb_reg_decoder.sv
src/gpio_port_regs.sv
src/button_debounce.sv
src/hex_display.sv
src/ghrd_io_top.sv
verification/ghrd_io_top_tb.sv

/* Makefile */
# Verilator build for the GHRD IO block and its testbench

VERILATOR  ?= verilator
FILELIST   := ghrd_io_top.f
RTL_TOP    := ghrd_io_top
TB_TOP     := ghrd_io_top_tb
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# lint the design top, the file list also pulls in the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# the simulation binary exits nonzero on $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/ghrd_io_top_tb.sv */
/*
 * Testbench for ghrd_io_top with debounce and hold shortened to 4 and 8 cycles.
 * Steps come from a table built at time zero; the first mismatch ends the run.
 */
module ghrd_io_top_tb;

	localparam int GPIO_WIDTH = 32;
	localparam int KEY_WIDTH  = 2;
	localparam int NUM_SEGS   = 6;
	localparam logic [31:0] HEX_MASK = (32'd1 << (4 * NUM_SEGS)) - 32'd1;

	typedef enum logic [2:0] {ST_WRITE, ST_READ, ST_PINS, ST_WAIT, ST_KEYS} step_kind_e;

	typedef struct packed {
		step_kind_e  kind;
		logic [2:0]  word;          // register word address
		logic [31:0] data;          // write data, pin word or key_n level
		logic [31:0] expect_data;   // read word or pulse count
		logic        expect_err;
		int          cycles;
	} step_t;

	// standard gfedcba shapes for 0..F, lit segment = 1
	localparam logic [6:0] SEG_ON [16] = '{
		7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
		7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
	};

	logic                    clk;
	logic                    rst;
	ghrd_io_pkg::apb_req_t   apb_req;
	ghrd_io_pkg::apb_rsp_t   apb_rsp;
	logic [GPIO_WIDTH-1:0]   gpio_in;
	logic [GPIO_WIDTH-1:0]   gpio_out;
	logic [GPIO_WIDTH-1:0]   gpio_oe;
	logic [KEY_WIDTH-1:0]    key_n;
	logic                    cold_reset_req;
	ghrd_io_pkg::seg_t       seg [NUM_SEGS];

	step_t steps [$];
	int    seed          = 64;
	int    pulse_count   = 0;
	int    cycle_count   = 0;
	int    timeout_limit = 1000000;   // replaced once the table exists

	ghrd_io_top #(
		.GPIO_WIDTH      (GPIO_WIDTH),
		.KEY_WIDTH       (KEY_WIDTH),
		.NUM_SEGS        (NUM_SEGS),
		.DEBOUNCE_CYCLES (4),
		.HOLD_CYCLES     (8)
	) DUT (
		.clk            (clk),
		.rst            (rst),
		.apb_req        (apb_req),
		.apb_rsp        (apb_rsp),
		.gpio_in        (gpio_in),
		.gpio_out       (gpio_out),
		.gpio_oe        (gpio_oe),
		.key_n          (key_n),
		.cold_reset_req (cold_reset_req),
		.seg            (seg)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ======================================================================
	// failure reporting and compares
	// ======================================================================
	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			stop_on_failure($sformatf("ERR t=%0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_seg(input string name, input ghrd_io_pkg::seg_t exp,
			input ghrd_io_pkg::seg_t act);
		if (act !== exp)
			stop_on_failure($sformatf("ERR t=%0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_rsp(input string name, input ghrd_io_pkg::apb_rsp_t exp,
			input ghrd_io_pkg::apb_rsp_t act, input logic cmp_data);
		if (act.pready !== exp.pready)
			stop_on_failure($sformatf("ERR t=%0t %s.pready expected %b got %b",
				$time, name, exp.pready, act.pready));
		if (cmp_data && act.prdata !== exp.prdata)
			stop_on_failure($sformatf("ERR t=%0t %s.prdata expected %h got %h",
				$time, name, exp.prdata, act.prdata));
		if (act.pslverr !== exp.pslverr)
			stop_on_failure($sformatf("ERR t=%0t %s.pslverr expected %b got %b",
				$time, name, exp.pslverr, act.pslverr));
	endtask

	function automatic ghrd_io_pkg::seg_t seg_expect(input logic [3:0] nib);
		return ~SEG_ON[nib];   // pins are active low
	endfunction

	// ======================================================================
	// bus and step drivers
	// ======================================================================
	task automatic apb_transfer(input logic wr, input logic [2:0] word, input logic [31:0] wdata,
			output ghrd_io_pkg::apb_rsp_t rsp);
		@(negedge clk);   // setup phase
		apb_req.paddr   = {word, 2'b00};
		apb_req.pwrite  = wr;
		apb_req.pwdata  = wdata;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge clk);
		apb_req.penable = 1'b1;
		@(posedge clk);   // access phase ends on this edge
		rsp = apb_rsp;    // response from before the edge
		@(negedge clk);
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
	endtask

	// pin side of a register that was just written or read
	task automatic check_pins(input step_t s);
		if (s.word == ghrd_io_pkg::REG_GPIO_OUT)
			check_word("gpio_out", s.expect_data, gpio_out);
		if (s.word == ghrd_io_pkg::REG_GPIO_OE)
			check_word("gpio_oe", s.expect_data, gpio_oe);
		if (s.word == ghrd_io_pkg::REG_HEX) begin
			for (int k = 0; k < NUM_SEGS; k++)
				check_seg($sformatf("seg[%0d]", k), seg_expect(s.expect_data[4*k +: 4]), seg[k]);
		end
	endtask

	task automatic run_step(input step_t s, input int idx);
		ghrd_io_pkg::apb_rsp_t rsp;
		ghrd_io_pkg::apb_rsp_t exp;
		int                    start;
		case (s.kind)
			ST_WRITE, ST_READ: begin
				apb_transfer(s.kind == ST_WRITE, s.word, s.data, rsp);
				exp.prdata  = s.expect_data;
				exp.pready  = 1'b1;
				exp.pslverr = s.expect_err;
				check_rsp($sformatf("apb_rsp (step %0d)", idx), exp, rsp, s.kind == ST_READ);
				if (!s.expect_err)
					check_pins(s);
			end
			ST_PINS: begin
				@(negedge clk);
				gpio_in = s.data;
				repeat (s.cycles) @(posedge clk);
			end
			ST_KEYS: begin
				start = pulse_count;
				@(negedge clk);
				key_n = s.data[KEY_WIDTH-1:0];   // level stays after the step
				repeat (s.cycles) @(posedge clk);
				check_word($sformatf("cold_reset_req pulses (step %0d)", idx),
					s.expect_data, pulse_count - start);
			end
			default: repeat (s.cycles) @(posedge clk);
		endcase
	endtask

	function automatic void add_step(input step_kind_e kind, input logic [2:0] word,
			input logic [31:0] data, input logic [31:0] expect_data, input logic expect_err,
			input int cycles);
		step_t s;
		s = '{kind, word, data, expect_data, expect_err, cycles};
		steps.push_back(s);
	endfunction

	// ======================================================================
	// stimulus table
	// ======================================================================
	function automatic void build_table();
		logic [31:0] r;
		logic [31:0] last_out;
		logic [31:0] last_oe;
		logic [31:0] pin_val;
		logic [31:0] hex_vals [4];
		hex_vals = '{32'h0054_3210, 32'h00BA_9876, 32'hFF10_FEDC, 32'hA512_3456};
		// state after reset, every digit shows 0
		add_step(ST_READ, ghrd_io_pkg::REG_HEX, 32'd0, 32'd0, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_OUT, 32'd0, 32'd0, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_OE, 32'd0, 32'd0, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_BUTTONS, 32'd0, 32'd0, 1'b0, 3);
		for (int i = 0; i < 4; i++) begin   // random output and enable words
			last_out = $random(seed);
			add_step(ST_WRITE, ghrd_io_pkg::REG_GPIO_OUT, last_out, last_out, 1'b0, 3);
			add_step(ST_READ, ghrd_io_pkg::REG_GPIO_OUT, 32'd0, last_out, 1'b0, 3);
			last_oe = $random(seed);
			add_step(ST_WRITE, ghrd_io_pkg::REG_GPIO_OE, last_oe, last_oe, 1'b0, 3);
			add_step(ST_READ, ghrd_io_pkg::REG_GPIO_OE, 32'd0, last_oe, 1'b0, 3);
		end
		// pin values, two edges through the synchronizer
		r = 32'h5A3C_F00F;
		add_step(ST_PINS, 3'd0, r, 32'd0, 1'b0, 2);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_IN, 32'd0, r, 1'b0, 3);
		pin_val = 32'hA5C3_0F96;
		add_step(ST_PINS, 3'd0, pin_val, 32'd0, 1'b0, 2);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_IN, 32'd0, pin_val, 1'b0, 3);
		foreach (hex_vals[i]) begin   // covers all sixteen digit shapes
			r = hex_vals[i] & HEX_MASK;
			add_step(ST_WRITE, ghrd_io_pkg::REG_HEX, hex_vals[i], r, 1'b0, 3);
			add_step(ST_READ, ghrd_io_pkg::REG_HEX, 32'd0, r, 1'b0, 3);
		end
		// faults, then prove nothing moved
		for (int w = 5; w < 8; w++) begin
			add_step(ST_READ, 3'(w), 32'd0, 32'd0, 1'b1, 3);
			add_step(ST_WRITE, 3'(w), 32'hFFFF_FFFF, 32'd0, 1'b1, 3);
		end
		add_step(ST_WRITE, ghrd_io_pkg::REG_GPIO_IN, 32'h1234_5678, 32'd0, 1'b1, 3);
		add_step(ST_WRITE, ghrd_io_pkg::REG_BUTTONS, 32'hFFFF_FFFF, 32'd0, 1'b1, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_IN, 32'd0, pin_val, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_OUT, 32'd0, last_out, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_GPIO_OE, 32'd0, last_oe, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_HEX, 32'd0, r, 1'b0, 3);
		add_step(ST_READ, ghrd_io_pkg::REG_BUTTONS, 32'd0, 32'd0, 1'b0, 3);
		// keys: short glitch read back right away, single key, both keys
		add_step(ST_KEYS, 3'd0, 32'h2, 32'd0, 1'b0, 2);
		add_step(ST_KEYS, 3'd0, 32'h3, 32'd0, 1'b0, 1);
		add_step(ST_READ, ghrd_io_pkg::REG_BUTTONS, 32'd0, 32'd0, 1'b0, 3);
		add_step(ST_KEYS, 3'd0, 32'h2, 32'd0, 1'b0, 30);
		add_step(ST_READ, ghrd_io_pkg::REG_BUTTONS, 32'd0, 32'h1, 1'b0, 3);
		add_step(ST_KEYS, 3'd0, 32'h3, 32'd0, 1'b0, 10);
		add_step(ST_KEYS, 3'd0, 32'h0, 32'd1, 1'b0, 30);
		add_step(ST_READ, ghrd_io_pkg::REG_BUTTONS, 32'd0, 32'h3, 1'b0, 3);
		add_step(ST_KEYS, 3'd0, 32'h3, 32'd0, 1'b0, 10);
		add_step(ST_READ, ghrd_io_pkg::REG_BUTTONS, 32'd0, 32'd0, 1'b0, 3);
	endfunction

	// ======================================================================
	// monitors and main sequence
	// ======================================================================
	always @(negedge clk) begin
		if (!rst && cold_reset_req)
			pulse_count++;   // one count per high cycle
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_limit)
			stop_on_failure($sformatf("timeout: steps still running after %0d cycles",
				cycle_count));
	end

	initial begin
		int total;
		rst     = 1'b1;
		apb_req = '0;
		gpio_in = '0;
		key_n   = '1;   // keys released
		build_table();
		total = 0;
		foreach (steps[i])
			total += steps[i].cycles;
		timeout_limit = 2 * total + 100;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (steps[i])
			run_step(steps[i], i);
		check_word("cold_reset_req total pulses", 32'd1, pulse_count);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* src/ghrd_io_top.sv */
/*
 * Soft-logic IO block: APB register decoder with GPIO, keys and hex display.
 * GPIO pins are split into out, enable and in; pad tristates live outside.
 * KEY_WIDTH must be at least 2 for the cold-reset hold detector.
 */
module ghrd_io_top #(
	parameter int GPIO_WIDTH      = 32,
	parameter int KEY_WIDTH       = 2,
	parameter int NUM_SEGS        = 6,
	parameter int DEBOUNCE_CYCLES = 50000,   // 1 ms at 50 MHz
	parameter int HOLD_CYCLES     = 1 << 24  // about a third of a second
) (
	input  logic                    clk,
	input  logic                    rst,
	input  ghrd_io_pkg::apb_req_t   apb_req,
	output ghrd_io_pkg::apb_rsp_t   apb_rsp,
	input  logic [GPIO_WIDTH-1:0]   gpio_in,
	output logic [GPIO_WIDTH-1:0]   gpio_out,
	output logic [GPIO_WIDTH-1:0]   gpio_oe,
	input  logic [KEY_WIDTH-1:0]    key_n,
	output logic                    cold_reset_req,
	output ghrd_io_pkg::seg_t       seg [NUM_SEGS]
);

	ghrd_io_pkg::reg_wr_t                reg_wr;    // write broadcast
	ghrd_io_pkg::gpio_rd_t               gpio_rd;
	logic [ghrd_io_pkg::BUS_WIDTH-1:0]   key_rd;
	logic [ghrd_io_pkg::BUS_WIDTH-1:0]   hex_rd;

	// ======================================================================
	// bus side
	// ======================================================================
	apb_reg_decoder u_decoder (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.reg_wr  (reg_wr),
		.gpio_rd (gpio_rd),
		.key_rd  (key_rd),
		.hex_rd  (hex_rd)
	);

	// ======================================================================
	// peers
	// ======================================================================
	gpio_port_regs #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (
		.clk      (clk),
		.rst      (rst),
		.reg_wr   (reg_wr),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe),
		.gpio_rd  (gpio_rd)
	);

	button_debounce #(
		.KEY_WIDTH       (KEY_WIDTH),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
		.HOLD_CYCLES     (HOLD_CYCLES)
	) u_keys (
		.clk            (clk),
		.rst            (rst),
		.key_n          (key_n),
		.key_rd         (key_rd),
		.cold_reset_req (cold_reset_req)
	);

	hex_display #(.NUM_SEGS(NUM_SEGS)) u_hex (
		.clk    (clk),
		.rst    (rst),
		.reg_wr (reg_wr),
		.hex_rd (hex_rd),
		.seg    (seg)
	);

endmodule

/* src/hex_display.sv */
/*
 * Display value register driving NUM_SEGS active-low seven-segment digits.
 * Digit k shows nibble k as 0..F; bits above 4*NUM_SEGS are dropped.
 * NUM_SEGS must be 1 to 8.
 */
module hex_display #(
	parameter int NUM_SEGS = 6
) (
	input  logic                                clk,
	input  logic                                rst,
	input  ghrd_io_pkg::reg_wr_t                reg_wr,
	output logic [ghrd_io_pkg::BUS_WIDTH-1:0]   hex_rd,
	output ghrd_io_pkg::seg_t                   seg [NUM_SEGS]
);

	logic [4*NUM_SEGS-1:0] hex_val;

	// active-high gfedcba pattern, inverted on the way out
	function automatic ghrd_io_pkg::seg_t hex_to_seg(input logic [3:0] nib);
		logic [6:0] on;
		case (nib)
			4'h0: on = 7'h3F;
			4'h1: on = 7'h06;
			4'h2: on = 7'h5B;
			4'h3: on = 7'h4F;
			4'h4: on = 7'h66;
			4'h5: on = 7'h6D;
			4'h6: on = 7'h7D;
			4'h7: on = 7'h07;
			4'h8: on = 7'h7F;
			4'h9: on = 7'h6F;
			4'hA: on = 7'h77;
			4'hB: on = 7'h7C;   // lower case b
			4'hC: on = 7'h39;
			4'hD: on = 7'h5E;   // lower case d
			4'hE: on = 7'h79;
			default: on = 7'h71;   // F
		endcase
		return ~on;
	endfunction

	// ======================================================================
	// value register
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst)
			hex_val <= '0;   // every digit shows 0
		else if (reg_wr.we && (reg_wr.addr == ghrd_io_pkg::REG_HEX))
			hex_val <= reg_wr.wdata[4*NUM_SEGS-1:0];
	end

	always_comb begin
		hex_rd = '0;
		hex_rd[4*NUM_SEGS-1:0] = hex_val;
	end

	// one decoder per digit
	always_comb begin
		for (int k = 0; k < NUM_SEGS; k++)
			seg[k] = hex_to_seg(hex_val[4*k +: 4]);
	end

endmodule

/* src/button_debounce.sv */
/*
 * Key debouncer with active-low inputs; a debounced 1 means pressed.
 * A level must hold DEBOUNCE_CYCLES cycles to be taken (latency +2 for sync).
 * Keys 0 and 1 held together for HOLD_CYCLES give one cold_reset_req pulse.
 */
module button_debounce #(
	parameter int KEY_WIDTH       = 2,          // at least 2
	parameter int DEBOUNCE_CYCLES = 50000,
	parameter int HOLD_CYCLES     = 1 << 24
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [KEY_WIDTH-1:0]                key_n,
	output logic [ghrd_io_pkg::BUS_WIDTH-1:0]   key_rd,
	output logic                                cold_reset_req
);

	localparam int DB_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);
	localparam logic [DB_W-1:0] DB_LAST = DB_W'(DEBOUNCE_CYCLES - 1);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_CYCLES - 1);

	typedef enum logic [1:0] {
		HOLD_IDLE,
		HOLD_COUNT,
		HOLD_FIRED   // wait for release
	} hold_state_e;

	logic [KEY_WIDTH-1:0]   press_meta;
	logic [KEY_WIDTH-1:0]   press_sync;   // 1 = pressed, not yet filtered
	logic [KEY_WIDTH-1:0]   press_db;
	logic [DB_W-1:0]        db_cnt [KEY_WIDTH];
	hold_state_e            hold_state;
	logic [HOLD_W-1:0]      hold_cnt;
	logic                   both_held;

	// ======================================================================
	// per-key sync and debounce
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			press_meta <= '0;
			press_sync <= '0;
			press_db   <= '0;
			for (int k = 0; k < KEY_WIDTH; k++)
				db_cnt[k] <= '0;
		end else begin
			press_meta <= ~key_n;   // flip polarity on entry
			press_sync <= press_meta;
			for (int k = 0; k < KEY_WIDTH; k++) begin
				if (press_sync[k] == press_db[k]) begin
					db_cnt[k] <= '0;   // bounce back restarts the count
				end else if (db_cnt[k] == DB_LAST) begin
					press_db[k] <= press_sync[k];
					db_cnt[k]   <= '0;
				end else begin
					db_cnt[k] <= db_cnt[k] + 1'b1;
				end
			end
		end
	end

	always_comb begin
		key_rd = '0;
		key_rd[KEY_WIDTH-1:0] = press_db;
	end

	// ======================================================================
	// both-keys hold detector
	// ======================================================================
	assign both_held = press_db[0] & press_db[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_state     <= HOLD_IDLE;
			hold_cnt       <= '0;
			cold_reset_req <= 1'b0;
		end else begin
			cold_reset_req <= 1'b0;
			case (hold_state)
				HOLD_IDLE: begin
					hold_cnt <= '0;
					if (both_held)
						hold_state <= HOLD_COUNT;
				end
				HOLD_COUNT: begin
					if (!both_held) begin
						hold_state <= HOLD_IDLE;
					end else if (hold_cnt == HOLD_LAST) begin
						hold_state     <= HOLD_FIRED;
						cold_reset_req <= 1'b1;   // the single pulse
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				default: begin   // HOLD_FIRED
					if (!both_held)
						hold_state <= HOLD_IDLE;
				end
			endcase
		end
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (rst)
		cold_reset_req |=> !cold_reset_req)
		else $error("cold_reset_req high for more than one cycle");

endmodule

/* src/gpio_port_regs.sv */
/*
 * GPIO output and output-enable registers plus a two-flop input synchronizer.
 * Writes keep the low GPIO_WIDTH bits; GPIO_WIDTH must be 1 to 32.
 * Pin changes show up in REG_GPIO_IN two clock edges later.
 */
module gpio_port_regs #(
	parameter int GPIO_WIDTH = 32
) (
	input  logic                    clk,
	input  logic                    rst,
	input  ghrd_io_pkg::reg_wr_t    reg_wr,
	input  logic [GPIO_WIDTH-1:0]   gpio_in,
	output logic [GPIO_WIDTH-1:0]   gpio_out,
	output logic [GPIO_WIDTH-1:0]   gpio_oe,
	output ghrd_io_pkg::gpio_rd_t   gpio_rd
);

	logic                    wr_out;
	logic                    wr_oe;
	logic [GPIO_WIDTH-1:0]   in_meta;   // first stage, may go metastable
	logic [GPIO_WIDTH-1:0]   in_sync;   // safe to read

	assign wr_out = reg_wr.we && (reg_wr.addr == ghrd_io_pkg::REG_GPIO_OUT);
	assign wr_oe  = reg_wr.we && (reg_wr.addr == ghrd_io_pkg::REG_GPIO_OE);

	// ======================================================================
	// output side
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			gpio_out <= '0;
			gpio_oe  <= '0;   // all pins start as inputs
		end else begin
			if (wr_out)
				gpio_out <= reg_wr.wdata[GPIO_WIDTH-1:0];   // upper bits dropped
			if (wr_oe)
				gpio_oe <= reg_wr.wdata[GPIO_WIDTH-1:0];
		end
	end

	// ======================================================================
	// input side
	// ======================================================================
	// pins are asynchronous to clk
	always_ff @(posedge clk) begin
		in_meta <= gpio_in;
		in_sync <= in_meta;
	end

	// readback words, zero above GPIO_WIDTH
	always_comb begin
		gpio_rd = '0;
		gpio_rd.out_word[GPIO_WIDTH-1:0] = gpio_out;
		gpio_rd.oe_word[GPIO_WIDTH-1:0]  = gpio_oe;
		gpio_rd.in_word[GPIO_WIDTH-1:0]  = in_sync;
	end

endmodule

/* src/apb_reg_decoder.sv */
/*
 * APB slave with zero wait states; every transfer is setup plus access.
 * Faulting transfers (unmapped, or write to a read-only word) raise pslverr,
 * change nothing and read back as zero.
 */
module apb_reg_decoder (
	input  logic                                clk,
	input  logic                                rst,
	input  ghrd_io_pkg::apb_req_t               apb_req,
	output ghrd_io_pkg::apb_rsp_t               apb_rsp,
	output ghrd_io_pkg::reg_wr_t                reg_wr,
	input  ghrd_io_pkg::gpio_rd_t               gpio_rd,
	input  logic [ghrd_io_pkg::BUS_WIDTH-1:0]   key_rd,
	input  logic [ghrd_io_pkg::BUS_WIDTH-1:0]   hex_rd
);

	logic                                 setup_ph;
	logic                                 access_ph;
	logic [ghrd_io_pkg::ADDR_WIDTH-3:0]   word;      // byte addr minus lane bits
	logic                                 mapped;
	logic                                 writable;
	logic                                 fault;
	logic [ghrd_io_pkg::BUS_WIDTH-1:0]    rdata;

	assign setup_ph  = apb_req.psel & ~apb_req.penable;
	assign access_ph = apb_req.psel & apb_req.penable;
	assign word      = apb_req.paddr[ghrd_io_pkg::ADDR_WIDTH-1:2];

	// ======================================================================
	// address decode and read mux
	// ======================================================================
	always_comb begin
		mapped   = 1'b1;
		writable = 1'b0;
		rdata    = '0;
		case (word)
			ghrd_io_pkg::REG_GPIO_OUT: begin
				writable = 1'b1;
				rdata    = gpio_rd.out_word;
			end
			ghrd_io_pkg::REG_GPIO_OE: begin
				writable = 1'b1;
				rdata    = gpio_rd.oe_word;
			end
			ghrd_io_pkg::REG_GPIO_IN: rdata = gpio_rd.in_word;
			ghrd_io_pkg::REG_BUTTONS: rdata = key_rd;
			ghrd_io_pkg::REG_HEX: begin
				writable = 1'b1;
				rdata    = hex_rd;
			end
			default: mapped = 1'b0;   // words 5..7
		endcase
	end

	assign fault = ~mapped | (apb_req.pwrite & ~writable);

	// response, no wait states ever
	always_comb begin
		apb_rsp.pready  = access_ph;
		apb_rsp.pslverr = access_ph & fault;
		apb_rsp.prdata  = (access_ph & ~apb_req.pwrite & ~fault) ? rdata : '0;
	end

	// write strobe, peers latch on the edge closing the access phase
	always_comb begin
		reg_wr.we    = access_ph & apb_req.pwrite & ~fault;
		reg_wr.addr  = ghrd_io_pkg::reg_addr_e'(word);
		reg_wr.wdata = apb_req.pwdata;
	end

	// ======================================================================
	// protocol checks
	// ======================================================================
	// master never raises penable outside a selected transfer
	a_penable_psel: assert property (@(posedge clk) disable iff (rst)
		apb_req.penable |-> apb_req.psel)
		else $error("apb penable without psel");

	// setup is always followed by a completing access phase
	a_setup_access: assert property (@(posedge clk) disable iff (rst)
		setup_ph |=> (apb_req.psel && apb_req.penable && apb_rsp.pready))
		else $error("apb access phase did not follow setup");

endmodule

/* src/ghrd_io_pkg.sv */
/*
 * Shared widths and types for the APB register block and its peers.
 * Register map is word addressed; byte address bits [1:0] are ignored.
 * Word addresses 5 to 7 are unmapped and answer with pslverr.
 */
package ghrd_io_pkg;

	// ======================================================================
	// bus geometry
	// ======================================================================
	localparam int BUS_WIDTH  = 32;
	localparam int ADDR_WIDTH = 5;   // eight word registers

	// word address of each register, i.e. paddr[4:2]
	typedef enum logic [ADDR_WIDTH-3:0] {
		REG_GPIO_OUT = 3'd0,   // rw
		REG_GPIO_OE  = 3'd1,   // rw
		REG_GPIO_IN  = 3'd2,   // ro, synchronized pins
		REG_BUTTONS  = 3'd3,   // ro, debounced keys
		REG_HEX      = 3'd4    // rw, display nibbles
	} reg_addr_e;

	// ======================================================================
	// host bus
	// ======================================================================
	// master side of the APB slave port
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] paddr;
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [BUS_WIDTH-1:0]  pwdata;
	} apb_req_t;

	// slave answer, only meaningful in the access phase
	typedef struct packed {
		logic [BUS_WIDTH-1:0] prdata;
		logic                 pready;
		logic                 pslverr;
	} apb_rsp_t;

	// write strobe broadcast to every peer
	typedef struct packed {
		logic                 we;      // one cycle per accepted write
		reg_addr_e            addr;
		logic [BUS_WIDTH-1:0] wdata;
	} reg_wr_t;

	// GPIO readback, each word zero-extended to the bus
	typedef struct packed {
		logic [BUS_WIDTH-1:0] out_word;
		logic [BUS_WIDTH-1:0] oe_word;
		logic [BUS_WIDTH-1:0] in_word;
	} gpio_rd_t;

	// one seven-segment digit
	// active low, bit 0 = seg a ... bit 6 = seg g
	typedef logic [6:0] seg_t;

endpackage
